// File: src/scope_pkg.sv
// capture RAM geometry, trigger bounds, pacing and timeout constants
package scope_pkg;

	// capture RAM one byte wide per channel
	localparam int RAM_AW       = 12;
	localparam int RAM_DEPTH    = 1 << RAM_AW; // 4096 samples per channel
	localparam int NUM_CHANNELS = 4;

	typedef logic [RAM_AW-1:0] ram_addr_t;
	typedef logic [7:0]        sample_t;

	// trigger point limits keep a few samples either side of the trigger
	localparam int TRIG_POINT_MIN   = 4;
	localparam int TRIG_POINT_MAX   = RAM_DEPTH - 16;
	localparam int TRIG_POINT_RESET = RAM_DEPTH / 4; // quarter of the screen

	// log2 of the cycles between serial bytes
	localparam int PACE_BITS_MAX   = 30;
	localparam int PACE_BITS_RESET = 5;

	// give up waiting for a capture after this many cycles
	localparam int READOUT_TIMEOUT = 100_000_000;

	// board ID before chain enumeration
	localparam int ID_UNASSIGNED = 200;

endpackage

// File: src/cmd_pkg.sv
// serial command opcodes, command ID ranges, argument counts and argument word type
package cmd_pkg;

	typedef logic [7:0] opcode_t;

	// ID-qualified ranges of RANGE_WIDTH codes each
	localparam int      RANGE_WIDTH      = 10;
	localparam opcode_t ID_ASSIGN_BASE   = 8'd0;  // set my ID, forward ID+1
	localparam opcode_t READOUT_SEL_BASE = 8'd10; // read out board n
	localparam opcode_t LAST_SEL_BASE    = 8'd20; // board n is last in the chain
	localparam opcode_t ACTIVE_SEL_BASE  = 8'd30; // make board n active

	// broadcast opcodes
	localparam opcode_t OP_PRIME       = 8'd100;
	localparam opcode_t OP_ROLL_ON     = 8'd101;
	localparam opcode_t OP_ROLL_OFF    = 8'd102;
	localparam opcode_t OP_TRIG_POINT  = 8'd121;
	localparam opcode_t OP_SAMPLES     = 8'd122;
	localparam opcode_t OP_SEND_INC    = 8'd123;
	localparam opcode_t OP_PACE        = 8'd125;
	localparam opcode_t OP_TRIG_THRESH = 8'd127;
	localparam opcode_t OP_AUTOREARM   = 8'd139;

	// argument bytes that follow the opcode, zero for none
	function automatic logic [1:0] arg_count(input opcode_t op);
		case (op)
			OP_TRIG_POINT, OP_SAMPLES:            return 2'd2; // big endian 16 bit
			OP_SEND_INC, OP_PACE, OP_TRIG_THRESH: return 2'd1;
			default:                              return 2'd0;
		endcase
	endfunction

	// kept opcodes that carry no argument
	function automatic logic is_plain_op(input opcode_t op);
		return (op == OP_PRIME) || (op == OP_ROLL_ON) || (op == OP_ROLL_OFF) ||
			(op == OP_AUTOREARM);
	endfunction

	// argument word filled bytewise by the parser and read as one value by the config block
	typedef union packed {
		struct packed {
			logic [7:0] hi; // first of two bytes
			logic [7:0] lo; // second byte, or the only one
		} b;
		logic [15:0] word;
	} cmd_arg_u;

endpackage

// File: src/node_ifs.sv
// cmd_if between parser, config and readout, cfg_if between config and readout
`timescale 1ns/10ps

interface cmd_if;
	import cmd_pkg::*;

	logic     cfg_wr;       // strobe, full command with its arguments
	opcode_t  opcode;
	cmd_arg_u arg;
	logic     readout_go;   // strobe, this board is selected for readout
	logic     readout_busy; // level, high until the readout ends

	modport parser (output cfg_wr, opcode, arg, readout_go, input readout_busy);
	modport configure (input cfg_wr, opcode, arg);
	modport readout (input readout_go, output readout_busy);

endinterface

interface cfg_if;
	import scope_pkg::*;

	ram_addr_t  trigger_point;
	ram_addr_t  samples_to_send; // 0 reads the whole depth
	logic [3:0] send_inc;        // log2 of the address stride
	logic [4:0] pace_bits;       // pace counter bit that paces the bytes
	logic       autorearm;
	logic       rearm;           // strobe back from readout at the end

	modport configure (
		output trigger_point, samples_to_send, send_inc, pace_bits, autorearm,
		input rearm
	);
	modport readout (
		input trigger_point, samples_to_send, send_inc, pace_bits, autorearm,
		output rearm
	);

endinterface

// File: src/cmd_parser.sv
// serial command receiver with argument collection, chain ID handling and byte forwarding
`timescale 1ns/10ps

module cmd_parser (
	input  logic              clk,
	input  logic              reset,
	input  logic              rx_ready,
	input  scope_pkg::sample_t rx_data,
	output scope_pkg::sample_t com_data,           // byte to the next board
	output logic              new_com_data,
	output logic              serial_passthrough,
	output logic [1:0]        master_clock,
	output logic              i_am_last,
	cmd_if.parser             cmd
);
	import scope_pkg::*;
	import cmd_pkg::*;

	typedef enum logic {ST_CMD, ST_ARGS} state_t;

	state_t     state;
	sample_t    my_id;
	logic [1:0] args_left; // argument bytes still to come
	logic       accept;

	// byte falls in the ten codes starting at base
	function automatic logic in_range(input sample_t b, input opcode_t base);
		return (b >= base) && (b < base + RANGE_WIDTH);
	endfunction

	// the ID part of a ranged command names this board
	function automatic logic id_hit(input sample_t b, input opcode_t base);
		return sample_t'(b - base) == my_id;
	endfunction

	// no bytes taken while a readout is starting or running
	assign accept = rx_ready && !cmd.readout_go && !cmd.readout_busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			state              <= ST_CMD;
			args_left          <= 2'd0;
			my_id              <= sample_t'(ID_UNASSIGNED);
			master_clock       <= 2'b00; // own master until enumerated
			i_am_last          <= 1'b0;
			serial_passthrough <= 1'b0;
			new_com_data       <= 1'b0;
			cmd.cfg_wr         <= 1'b0;
			cmd.readout_go     <= 1'b0;
		end else begin
			new_com_data   <= 1'b0; // strobes last one cycle
			cmd.cfg_wr     <= 1'b0;
			cmd.readout_go <= 1'b0;
			if (accept) begin
				if (state == ST_ARGS) begin
					new_com_data <= 1'b1; // arguments go down the chain too
					args_left    <= args_left - 2'd1;
					if (args_left == 2'd1) begin
						cmd.cfg_wr <= 1'b1;
						state      <= ST_CMD;
					end
				end else if (in_range(rx_data, ID_ASSIGN_BASE)) begin
					my_id        <= sample_t'(rx_data - ID_ASSIGN_BASE);
					master_clock <= (rx_data == ID_ASSIGN_BASE) ? 2'b00 : 2'b01; // others slave
					new_com_data <= 1'b1;
				end else if (in_range(rx_data, READOUT_SEL_BASE)) begin
					if (id_hit(rx_data, READOUT_SEL_BASE)) begin
						serial_passthrough <= 1'b0;
						cmd.readout_go     <= 1'b1; // our turn, not forwarded
					end else begin
						serial_passthrough <= 1'b1;
						new_com_data       <= 1'b1;
					end
				end else if (in_range(rx_data, LAST_SEL_BASE)) begin
					i_am_last    <= id_hit(rx_data, LAST_SEL_BASE);
					new_com_data <= 1'b1;
				end else if (in_range(rx_data, ACTIVE_SEL_BASE)) begin
					if (id_hit(rx_data, ACTIVE_SEL_BASE)) begin
						serial_passthrough <= 1'b0;
					end else begin
						serial_passthrough <= 1'b1;
						new_com_data       <= 1'b1;
					end
				end else if (arg_count(rx_data) != 2'd0) begin
					state        <= ST_ARGS;
					args_left    <= arg_count(rx_data);
					new_com_data <= 1'b1;
				end else if (is_plain_op(rx_data)) begin
					cmd.cfg_wr   <= 1'b1; // no arguments, apply at once
					new_com_data <= 1'b1;
				end
				// anything else is dropped
			end
		end
	end

	// forwarded byte, opcode and argument bytes
	always_ff @(posedge clk) begin
		if (accept) begin
			if (state == ST_ARGS) begin
				cmd.arg.b.hi <= cmd.arg.b.lo; // first of two ends up in hi
				cmd.arg.b.lo <= rx_data;
				com_data     <= rx_data;
			end else begin
				cmd.opcode <= rx_data;
				cmd.arg    <= '0;
				com_data   <= in_range(rx_data, ID_ASSIGN_BASE) ? rx_data + 8'd1 : rx_data;
			end
		end
	end

endmodule

// File: src/scope_config.sv
// trigger and readout settings with clamping, trigger prime and re-arm pulse
`timescale 1ns/10ps

module scope_config (
	input  logic                 clk,
	input  logic                 reset,
	cmd_if.configure             cmd,
	cfg_if.configure             cfg,
	output logic                 get_ext_data,    // prime the trigger
	output logic                 rolling_trigger,
	output scope_pkg::ram_addr_t trigger_point,
	output scope_pkg::sample_t   trig_thresh
);
	import scope_pkg::*;
	import cmd_pkg::*;

	logic [15:0] arg_word;
	ram_addr_t   tp_clamped;
	ram_addr_t   new_samples;
	logic [4:0]  pace_clamped;

	assign arg_word    = cmd.arg.word;
	assign new_samples = arg_word[RAM_AW-1:0];

	always_comb begin
		if (arg_word > TRIG_POINT_MAX)
			tp_clamped = ram_addr_t'(TRIG_POINT_MAX);
		else if (arg_word < TRIG_POINT_MIN)
			tp_clamped = ram_addr_t'(TRIG_POINT_MIN);
		else
			tp_clamped = arg_word[RAM_AW-1:0];
	end

	assign pace_clamped = (arg_word > PACE_BITS_MAX) ? 5'(PACE_BITS_MAX) : arg_word[4:0];

	assign cfg.trigger_point = trigger_point; // readout sees the same value

	always_ff @(posedge clk) begin
		if (reset) begin
			get_ext_data        <= 1'b0;
			rolling_trigger     <= 1'b1;
			trigger_point       <= ram_addr_t'(TRIG_POINT_RESET);
			trig_thresh         <= 8'h80; // mid scale
			cfg.samples_to_send <= '0;    // full depth
			cfg.send_inc        <= 4'd0;
			cfg.pace_bits       <= 5'(PACE_BITS_RESET);
			cfg.autorearm       <= 1'b0;
		end else begin
			// prime on command or when a finished readout asks for it
			get_ext_data <= (cmd.cfg_wr && cmd.opcode == OP_PRIME) || cfg.rearm;
			if (cmd.cfg_wr) begin
				case (cmd.opcode)
					OP_TRIG_POINT: trigger_point <= tp_clamped;
					OP_SAMPLES: begin
						cfg.samples_to_send <= new_samples;
						// keep the trigger inside a short window
						if (new_samples >= 5 && trigger_point > new_samples - 5)
							trigger_point <= new_samples >> 1;
					end
					OP_SEND_INC:    cfg.send_inc    <= arg_word[3:0];
					OP_PACE:        cfg.pace_bits   <= pace_clamped;
					OP_TRIG_THRESH: trig_thresh     <= arg_word[7:0];
					OP_ROLL_ON:     rolling_trigger <= 1'b1;
					OP_ROLL_OFF:    rolling_trigger <= 1'b0;
					OP_AUTOREARM:   cfg.autorearm   <= !cfg.autorearm;
					default: ; // prime handled above
				endcase
			end
		end
	end

endmodule

// File: src/readout_seq.sv
// capture RAM readout, channel rotation with stride and paced serial byte send
`timescale 1ns/10ps

module readout_seq (
	input  logic                 clk,
	input  logic                 reset,
	cmd_if.readout               cmd,
	cfg_if.readout               cfg,
	input  logic                 ext_data_ready, // capture finished
	input  scope_pkg::ram_addr_t wr_addr_trig,   // write address at trigger
	input  scope_pkg::sample_t   ram_out0,
	input  scope_pkg::sample_t   ram_out1,
	input  scope_pkg::sample_t   ram_out2,
	input  scope_pkg::sample_t   ram_out3,
	output logic                 rd_en,
	output scope_pkg::ram_addr_t rd_addr,
	input  logic                 tx_busy,
	output logic                 tx_start,
	output scope_pkg::sample_t   tx_data
);
	import scope_pkg::*;

	localparam int CNT_W = RAM_AW + 5; // offset plus the largest stride
	localparam int TMO_W = $clog2(READOUT_TIMEOUT + 1);
	localparam int CH_W  = $clog2(NUM_CHANNELS);

	typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_SEND, ST_HOLD} state_t;

	state_t             state;
	logic [PACE_BITS_MAX:0] pace_cnt; // free running
	logic               pace_bit, pace_phase;
	logic [TMO_W-1:0]   wait_cnt;
	logic [CNT_W-1:0]   offset, stride, next_offset, limit;
	logic [CH_W-1:0]    chan;
	logic               final_byte, addr_moved, can_send, chan_end;
	ram_addr_t          start_addr;
	sample_t            ram_word;

	assign pace_bit    = pace_cnt[cfg.pace_bits];
	assign stride      = CNT_W'(1) << cfg.send_inc;
	assign next_offset = offset + stride;
	assign limit       = (cfg.samples_to_send == '0) ? CNT_W'(RAM_DEPTH) : CNT_W'(cfg.samples_to_send);
	assign chan_end    = next_offset >= limit; // this channel is done after this byte
	// RAM word is valid one cycle after the address moved
	assign can_send    = !tx_busy && !addr_moved && (pace_bit != pace_phase);

	always_comb begin
		case (chan)
			2'd0:    ram_word = ram_out0;
			2'd1:    ram_word = ram_out1;
			2'd2:    ram_word = ram_out2;
			default: ram_word = ram_out3;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state            <= ST_IDLE;
			pace_cnt         <= '0;
			pace_phase       <= 1'b0;
			wait_cnt         <= '0;
			offset           <= '0;
			chan             <= '0;
			final_byte       <= 1'b0;
			addr_moved       <= 1'b0;
			rd_en            <= 1'b0;
			tx_start         <= 1'b0;
			cmd.readout_busy <= 1'b0;
			cfg.rearm        <= 1'b0;
		end else begin
			pace_cnt   <= pace_cnt + 1'b1;
			tx_start   <= 1'b0; // single cycle pulse
			cfg.rearm  <= 1'b0;
			addr_moved <= 1'b0;
			case (state)
				ST_IDLE: if (cmd.readout_go) begin
					cmd.readout_busy <= 1'b1;
					wait_cnt         <= '0;
					state            <= ST_WAIT;
				end
				ST_WAIT: begin
					wait_cnt <= wait_cnt + 1'b1;
					if (ext_data_ready) begin
						rd_en      <= 1'b1;
						offset     <= '0;
						chan       <= '0;
						final_byte <= 1'b0;
						addr_moved <= 1'b1;
						pace_phase <= pace_bit; // reference phase of the pace bit
						state      <= ST_SEND;
					end else if (wait_cnt >= TMO_W'(READOUT_TIMEOUT)) begin
						cmd.readout_busy <= 1'b0; // no capture, send nothing
						state            <= ST_IDLE;
					end
				end
				ST_SEND: if (can_send) begin
					tx_start   <= 1'b1;
					addr_moved <= 1'b1;
					state      <= ST_HOLD;
					if (chan_end) begin
						offset     <= '0;
						chan       <= chan + 1'b1;
						final_byte <= (chan == CH_W'(NUM_CHANNELS - 1));
					end else begin
						offset <= next_offset;
					end
				end
				ST_HOLD: if (pace_bit == pace_phase) begin // wait out the rest of the pace period
					if (final_byte) begin
						rd_en            <= 1'b0;
						cmd.readout_busy <= 1'b0;
						cfg.rearm        <= cfg.autorearm;
						state            <= ST_IDLE;
					end else begin
						state <= ST_SEND;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// read address and outgoing byte
	always_ff @(posedge clk) begin
		if (state == ST_WAIT && ext_data_ready) begin
			start_addr <= wr_addr_trig - cfg.trigger_point; // wraps modulo the depth
			rd_addr    <= wr_addr_trig - cfg.trigger_point;
		end else if (state == ST_SEND && can_send) begin
			tx_data <= ram_word;
			rd_addr <= chan_end ? start_addr : rd_addr + stride[RAM_AW-1:0]; // next channel restarts
		end
	end

endmodule

// File: src/scope_node.sv
// scope node top level wiring the parser, configuration and readout blocks
`timescale 1ns/10ps

module scope_node (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 rx_ready,
	input  scope_pkg::sample_t   rx_data,
	output scope_pkg::sample_t   com_data,
	output logic                 new_com_data,
	output logic                 serial_passthrough,
	output logic [1:0]           master_clock,
	output logic                 i_am_last,
	output logic                 get_ext_data,
	output logic                 rolling_trigger,
	output scope_pkg::ram_addr_t trigger_point,
	output scope_pkg::sample_t   trig_thresh,
	input  logic                 ext_data_ready,
	input  scope_pkg::ram_addr_t wr_addr_trig,
	input  scope_pkg::sample_t   ram_out0,
	input  scope_pkg::sample_t   ram_out1,
	input  scope_pkg::sample_t   ram_out2,
	input  scope_pkg::sample_t   ram_out3,
	output logic                 rd_en,
	output scope_pkg::ram_addr_t rd_addr,
	input  logic                 tx_busy,
	output logic                 tx_start,
	output scope_pkg::sample_t   tx_data
);
	cmd_if cmd_bus(); // commands and readout start
	cfg_if cfg_bus(); // settings for the readout

	cmd_parser parser_i (
		.clk, .reset, .rx_ready, .rx_data, .com_data, .new_com_data,
		.serial_passthrough, .master_clock, .i_am_last, .cmd(cmd_bus.parser)
	);

	scope_config config_i (
		.clk, .reset, .cmd(cmd_bus.configure), .cfg(cfg_bus.configure),
		.get_ext_data, .rolling_trigger, .trigger_point, .trig_thresh
	);

	readout_seq readout_i (
		.clk, .reset, .cmd(cmd_bus.readout), .cfg(cfg_bus.readout),
		.ext_data_ready, .wr_addr_trig, .ram_out0, .ram_out1, .ram_out2, .ram_out3,
		.rd_en, .rd_addr, .tx_busy, .tx_start, .tx_data
	);

endmodule

// File: tb/scope_node_asserts.sv
// concurrent assertions on the tx_start, new_com_data and rd_en strobes, bound to scope_node
`timescale 1ns/10ps

module scope_node_asserts (
	input logic clk,
	input logic reset,
	input logic tx_start,
	input logic tx_busy,
	input logic new_com_data,
	input logic rd_en
);
	int unsigned fail_count = 0; // failed assertions so far

	tx_start_pulse: assert property (@(posedge clk) disable iff (reset) tx_start |=> !tx_start)
		else begin
			$error("tx_start held high for more than one cycle");
			fail_count++;
		end

	// transmitter must be free when a byte starts
	tx_start_free: assert property (@(posedge clk) disable iff (reset)
		$rose(tx_start) |-> !$past(tx_busy))
		else begin
			$error("tx_start rose while tx_busy was high");
			fail_count++;
		end

	fwd_pulse: assert property (@(posedge clk) disable iff (reset) new_com_data |=> !new_com_data)
		else begin
			$error("new_com_data held high for more than one cycle");
			fail_count++;
		end

	tx_in_readout: assert property (@(posedge clk) disable iff (reset) tx_start |-> rd_en)
		else begin
			$error("tx_start high while rd_en was low");
			fail_count++;
		end

endmodule

bind scope_node scope_node_asserts asserts_i (.*);

// File: tb/tb_scope_node.sv
// scope node testbench with clock, reset, RAM and transmitter models, reference model and checks
`timescale 1ns/10ps

module tb_scope_node;
	import scope_pkg::*;
	import cmd_pkg::*;

	logic      clk, reset, rx_ready, new_com_data, serial_passthrough, i_am_last;
	logic      get_ext_data, rolling_trigger, ext_data_ready, rd_en, tx_busy, tx_start;
	logic [1:0] master_clock;
	sample_t   rx_data, com_data, trig_thresh, tx_data;
	sample_t   ram_out0, ram_out1, ram_out2, ram_out3;
	ram_addr_t trigger_point, wr_addr_trig, rd_addr;

	// reference model state
	int   m_id, m_tp, m_samples, m_inc, m_pace;
	logic m_pass, m_roll, m_autorearm;
	sample_t m_thresh;

	string   test_name;
	sample_t tx_q[$];  // bytes seen on the transmitter
	sample_t exp_q[$]; // bytes the readout order rule predicts
	int      prime_count = 0; // get_ext_data pulses
	int      busy_left = 0;
	int      cycle_count = 0;
	int      cycle_limit = 400; // grows with every command and readout

	scope_node dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	// capture RAM content of channel c at address a
	function automatic sample_t ram_byte(input ram_addr_t a, input int c);
		return a[7:0] ^ sample_t'(c * 'h3C);
	endfunction

	always @(posedge clk) begin // word follows the address by one cycle
		ram_out0 <= ram_byte(rd_addr, 0);
		ram_out1 <= ram_byte(rd_addr, 1);
		ram_out2 <= ram_byte(rd_addr, 2);
		ram_out3 <= ram_byte(rd_addr, 3);
	end

	// serial transmitter busy for 0 to 3 cycles after each start
	always @(posedge clk) begin
		if (tx_start) begin
			tx_q.push_back(tx_data);
			busy_left = $urandom_range(3, 0);
			tx_busy <= (busy_left != 0);
		end else if (busy_left > 0) begin
			busy_left--;
			tx_busy <= (busy_left != 0);
		end
	end

	always @(posedge clk) begin
		if (get_ext_data)
			prime_count++;
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Simulation failed");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic check_byte(input string what, input sample_t exp, input sample_t act);
		if (act !== exp) begin
			$display("MISMATCH %s %s: expected 'h%02h actual 'h%02h", test_name, what, exp, act);
			$display("Simulation failed");
			$fatal(1, "byte compare failed");
		end
	endtask

	task automatic check_addr(input string what, input ram_addr_t exp, input ram_addr_t act);
		if (act !== exp) begin
			$display("MISMATCH %s %s: expected %0d actual %0d", test_name, what, exp, act);
			$display("Simulation failed");
			$fatal(1, "address compare failed");
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("MISMATCH %s %s: expected %b actual %b", test_name, what, exp, act);
			$display("Simulation failed");
			$fatal(1, "flag compare failed");
		end
	endtask

	task automatic check_count(input string what, input int exp, input int act);
		if (act != exp) begin
			$display("MISMATCH %s %s: expected %0d actual %0d", test_name, what, exp, act);
			$display("Simulation failed");
			$fatal(1, "count compare failed");
		end
	endtask

	// sends one host byte and returns what was forwarded down the chain
	task automatic send_byte(input sample_t b, output logic fwd, output sample_t fwd_data);
		@(posedge clk);
		rx_ready <= 1'b1;
		rx_data  <= b;
		@(posedge clk);
		rx_ready <= 1'b0;
		@(negedge clk); // forward pulse is up by now
		fwd      = new_com_data;
		fwd_data = com_data;
	endtask

	function automatic void apply_model(input opcode_t op, input logic [15:0] arg);
		case (op)
			OP_TRIG_POINT: m_tp = (arg > TRIG_POINT_MAX) ? TRIG_POINT_MAX :
				(arg < TRIG_POINT_MIN) ? TRIG_POINT_MIN : int'(arg);
			OP_SAMPLES: begin
				m_samples = arg[11:0];
				if (m_samples >= 5 && m_tp > m_samples - 5)
					m_tp = m_samples / 2;
			end
			OP_SEND_INC:    m_inc = arg[3:0];
			OP_PACE:        m_pace = (arg[7:0] > PACE_BITS_MAX) ? PACE_BITS_MAX : arg[7:0];
			OP_TRIG_THRESH: m_thresh = arg[7:0];
			OP_ROLL_ON:     m_roll = 1'b1;
			OP_ROLL_OFF:    m_roll = 1'b0;
			OP_AUTOREARM:   m_autorearm = !m_autorearm;
			default: ;
		endcase
	endfunction

	task automatic check_config();
		check_addr("trigger_point", ram_addr_t'(m_tp), trigger_point);
		check_byte("trig_thresh", m_thresh, trig_thresh);
		check_flag("rolling_trigger", m_roll, rolling_trigger);
	endtask

	// broadcast command with 0 to 2 argument bytes sent high byte first
	task automatic send_cmd(input opcode_t op, input int nargs, input logic [15:0] arg);
		logic    fwd;
		sample_t fwd_data;
		cycle_limit += 400;
		send_byte(op, fwd, fwd_data);
		check_flag("opcode forwarded", 1'b1, fwd);
		check_byte("forwarded opcode", op, fwd_data);
		if (nargs == 2) begin
			send_byte(arg[15:8], fwd, fwd_data);
			check_flag("high arg forwarded", 1'b1, fwd);
			check_byte("forwarded high arg", arg[15:8], fwd_data);
		end
		if (nargs >= 1) begin
			send_byte(arg[7:0], fwd, fwd_data);
			check_flag("low arg forwarded", 1'b1, fwd);
			check_byte("forwarded low arg", arg[7:0], fwd_data);
		end
		apply_model(op, arg);
		repeat (3) @(negedge clk); // cfg_wr and then the registers
		check_config();
	endtask

	// active, readout or last select aimed at board target
	task automatic select_board(input opcode_t base, input int target);
		logic    fwd, hit;
		sample_t fwd_data, b;
		hit = (target == m_id);
		b   = sample_t'(base + target);
		cycle_limit += 400;
		send_byte(b, fwd, fwd_data);
		if (base == LAST_SEL_BASE) begin
			check_flag("last select forwarded", 1'b1, fwd);
			check_flag("i_am_last", hit, i_am_last);
		end else begin
			m_pass = !hit;
			check_flag("select forwarded", !hit, fwd);
			check_flag("serial_passthrough", m_pass, serial_passthrough);
		end
		if (fwd)
			check_byte("forwarded select", b, fwd_data);
	endtask

	function automatic void build_expected(input ram_addr_t trig_addr);
		ram_addr_t start;
		int        limit, stride, c, k;
		start  = trig_addr - ram_addr_t'(m_tp); // wraps over the depth
		limit  = (m_samples == 0) ? RAM_DEPTH : m_samples;
		stride = 1 << m_inc;
		exp_q.delete();
		for (c = 0; c < NUM_CHANNELS; c++)
			for (k = 0; k * stride < limit; k++)
				exp_q.push_back(ram_byte(start + ram_addr_t'(k * stride), c));
	endfunction

	task automatic run_readout(input int inc, input int samples, input int pace);
		ram_addr_t trig_addr;
		logic      fwd;
		sample_t   fwd_data;
		int        primes_before, i;
		send_cmd(OP_SEND_INC, 1, 16'(inc));
		send_cmd(OP_SAMPLES, 2, 16'(samples));
		send_cmd(OP_PACE, 1, 16'(pace));
		trig_addr = ram_addr_t'($urandom);
		build_expected(trig_addr);
		cycle_limit += 400 + 2 * 4 * m_samples * ((1 << (m_pace + 2)) + 8);
		@(posedge clk);
		wr_addr_trig   <= trig_addr;
		ext_data_ready <= 1'b1; // capture already done
		tx_q.delete();
		primes_before = prime_count;
		send_byte(sample_t'(READOUT_SEL_BASE + m_id), fwd, fwd_data);
		m_pass = 1'b0;
		check_flag("readout select forwarded", 1'b0, fwd);
		check_flag("serial_passthrough", m_pass, serial_passthrough);
		while (tx_q.size() < exp_q.size())
			@(negedge clk);
		repeat (1 << (m_pace + 2)) @(negedge clk); // let tx go quiet
		check_flag("rd_en after readout", 1'b0, rd_en);
		@(posedge clk);
		ext_data_ready <= 1'b0;
		check_count("bytes sent", exp_q.size(), tx_q.size());
		for (i = 0; i < exp_q.size(); i++)
			check_byte($sformatf("tx byte %0d", i), exp_q[i], tx_q[i]);
		check_count("rearm pulses", m_autorearm ? 1 : 0, prime_count - primes_before);
	endtask

	initial begin
		logic    fwd;
		sample_t fwd_data;
		int      id, other, n;
		void'($urandom(32'h9157b763));
		reset = 1'b1;
		rx_ready = 1'b0;
		rx_data = '0;
		ext_data_ready = 1'b0;
		wr_addr_trig = '0;
		tx_busy = 1'b0;
		ram_out0 = '0;
		ram_out1 = '0;
		ram_out2 = '0;
		ram_out3 = '0;
		m_id = ID_UNASSIGNED;
		m_tp = TRIG_POINT_RESET;
		m_samples = 0;
		m_inc = 0;
		m_pace = PACE_BITS_RESET;
		m_thresh = 8'd128;
		m_roll = 1'b1;
		m_pass = 1'b0;
		m_autorearm = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);

		test_name = "reset";
		check_config();
		check_flag("serial_passthrough", 1'b0, serial_passthrough);
		check_flag("i_am_last", 1'b0, i_am_last);
		check_flag("rd_en", 1'b0, rd_en);

		test_name = "id_assign";
		repeat (5) begin
			id = $urandom_range(9, 0);
			cycle_limit += 400;
			send_byte(sample_t'(ID_ASSIGN_BASE + id), fwd, fwd_data);
			m_id = id;
			check_flag("id forwarded", 1'b1, fwd);
			check_byte("forwarded id", sample_t'(id + 1), fwd_data);
			check_flag("master_clock[0]", id != 0, master_clock[0]); // board 0 is master
			check_flag("master_clock[1]", 1'b0, master_clock[1]);
		end

		test_name = "select";
		repeat (8) begin
			other = (m_id + $urandom_range(9, 1)) % 10;
			select_board(ACTIVE_SEL_BASE, other);
			select_board(READOUT_SEL_BASE, other);
			select_board(ACTIVE_SEL_BASE, m_id);
			select_board(LAST_SEL_BASE, $urandom_range(1, 0) ? m_id : other);
		end

		test_name = "config";
		repeat (30) begin
			case ($urandom_range(5, 0))
				0: send_cmd(OP_TRIG_POINT, 2, 16'($urandom));
				1: send_cmd(OP_TRIG_POINT, 2, 16'($urandom_range(TRIG_POINT_MAX + 40, 0)));
				2: send_cmd(OP_SAMPLES, 2, 16'($urandom_range(4200, 0)));
				3: send_cmd(OP_TRIG_THRESH, 1, 16'($urandom_range(255, 0)));
				4: send_cmd(OP_ROLL_ON, 0, 16'd0);
				default: send_cmd(OP_ROLL_OFF, 0, 16'd0);
			endcase
		end

		test_name = "readout";
		repeat (4) begin
			send_cmd(OP_TRIG_POINT, 2, 16'($urandom_range(RAM_DEPTH - 1, 0)));
			run_readout($urandom_range(2, 0), $urandom_range(40, 8), $urandom_range(3, 1));
		end

		test_name = "prime";
		n = prime_count;
		send_cmd(OP_PRIME, 0, 16'd0);
		check_count("get_ext_data pulses", 1, prime_count - n);

		test_name = "autorearm";
		send_cmd(OP_AUTOREARM, 0, 16'd0);
		run_readout($urandom_range(2, 0), $urandom_range(40, 8), $urandom_range(3, 1));

		if (dut_i.asserts_i.fail_count != 0) begin
			$display("%0d assertion failures during the run", dut_i.asserts_i.fail_count);
			$display("Simulation failed");
			$fatal(1, "assertion failures");
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

// File: all.f
src/scope_pkg.sv
src/cmd_pkg.sv
src/node_ifs.sv
src/cmd_parser.sv
src/scope_config.sv
src/readout_seq.sv
src/scope_node.sv
tb/scope_node_asserts.sv
tb/tb_scope_node.sv

// File: run.sh
#!/bin/sh
# compile and run the scope node testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_scope_node -o sim_scope_node
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

out=$(./obj_dir/sim_scope_node)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation returned status $status"
	exit 1
fi

if echo "$out" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1
